// File: cu_cfg.svh
////////////////////////////////////////
// compute-unit controller configuration
// FIFO sizes, field widths and unit ids
////////////////////////////////////////
`ifndef CU_CFG_SVH
`define CU_CFG_SVH

// source command FIFOs
`define CU_CMD_FIFO_DEPTH 8
`define CU_CMD_HEADROOM 2

// burst FIFO towards the host
`define CU_BURST_FIFO_DEPTH 16
`define CU_BURST_HEADROOM 8

// field widths
`define CU_ADDR_WIDTH 32
`define CU_TAG_WIDTH 8
`define CU_COUNT_WIDTH 32
`define CU_ID_WIDTH 2

// responses carrying this id go to the vertex-job port
`define CU_VERTEX_CONTROL_ID 0

`endif

// File: cu_pkg.sv
////////////////////////////////////////
// compute-unit controller types
// command, response, descriptor and FIFO status lines
////////////////////////////////////////
`default_nettype none

`include "cu_cfg.svh"

package cu_pkg;

	typedef logic [`CU_ID_WIDTH-1:0] cu_id_t;
	typedef logic [`CU_ADDR_WIDTH-1:0] address_t;
	typedef logic [`CU_TAG_WIDTH-1:0] tag_t;
	typedef logic [`CU_COUNT_WIDTH-1:0] count_t;

	// read command towards the host
	typedef struct packed {
		logic     valid;
		cu_id_t   cu_id;
		address_t address;
		tag_t     tag;
	} cmd_line_t;

	// read response from the host
	typedef struct packed {
		logic   valid;
		cu_id_t cu_id;
		tag_t   tag;
	} response_line_t;

	// run descriptor
	typedef struct packed {
		logic   valid;
		count_t num_vertices;
		count_t num_edges;
	} wed_t;

	typedef struct packed {
		logic valid;
		logic empty;
		logic full;
		logic alfull;
	} buffer_status_t;

endpackage

`default_nettype wire

// File: cmd_fifo.sv
////////////////////////////////////////
// show-ahead command FIFO
// circular buffer with full and almost-full flags
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module cmd_fifo
	import cu_pkg::*;
#(
	parameter int DEPTH = 8,
	parameter int HEADROOM = 2
) (
	input  logic           clock,
	input  logic           rstn,
	input  logic           push,
	input  cmd_line_t      data_in,
	input  logic           pop,
	output cmd_line_t      data_out,
	output buffer_status_t status
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	cmd_line_t mem [DEPTH];
	logic [AW-1:0] rd_ptr;
	logic [AW-1:0] wr_ptr;
	logic [CW-1:0] count;
	logic do_push;
	logic do_pop;

	// flags straight from the occupancy
	assign status.empty = (count == '0);
	assign status.full = (count == CW'(DEPTH));
	assign status.alfull = (count >= CW'(DEPTH - HEADROOM));
	assign status.valid = ~status.empty;

	assign do_push = push & ~status.full;
	assign do_pop = pop & ~status.empty;

	// head is visible while not empty
	assign data_out = status.empty ? '0 : mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// simultaneous push and pop leaves the count alone
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: cmd_arbiter.sv
////////////////////////////////////////
// round-robin arbiter for two command heads
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module cmd_arbiter
	import cu_pkg::*;
(
	input  logic            clock,
	input  logic            rstn,
	input  logic            enabled,
	input  logic            hold,
	input  cmd_line_t [1:0] heads,
	output logic [1:0]      pops,
	output cmd_line_t       cmd_out
);

	logic [1:0] req;
	logic grant;
	logic winner;
	// index of the source granted most recently
	logic last_grant;

	assign req[0] = heads[0].valid & ~hold & enabled;
	assign req[1] = heads[1].valid & ~hold & enabled;

	always_comb begin
		grant = 1'b1;
		winner = 1'b0;
		if (req[0] && req[1]) begin
			winner = ~last_grant;
		end else if (req[1]) begin
			winner = 1'b1;
		end else if (!req[0]) begin
			grant = 1'b0;
		end
	end

	// pop lands on the FIFO at the same edge the line is registered
	assign pops[0] = grant & ~winner;
	assign pops[1] = grant & winner;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			last_grant <= 1'b0;
			cmd_out <= '0;
		end else begin
			if (grant) begin
				last_grant <= winner;
				cmd_out <= heads[winner];
			end else begin
				cmd_out <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// File: response_router.sv
////////////////////////////////////////
// read response router
// splits responses by compute-unit id
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "cu_cfg.svh"

module response_router
	import cu_pkg::*;
(
	input  logic           clock,
	input  logic           rstn,
	input  logic           enabled,
	input  response_line_t response_in,
	output response_line_t vertex_response,
	output response_line_t algorithm_response
);

	logic to_vertex;

	assign to_vertex = (response_in.cu_id == cu_id_t'(`CU_VERTEX_CONTROL_ID));

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_response <= '0;
			algorithm_response <= '0;
		end else begin
			// the port not selected is zeroed in the same cycle
			if (enabled && response_in.valid) begin
				if (to_vertex) begin
					vertex_response <= response_in;
					algorithm_response <= '0;
				end else begin
					vertex_response <= '0;
					algorithm_response <= response_in;
				end
			end else begin
				vertex_response <= '0;
				algorithm_response <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// File: progress_monitor.sv
////////////////////////////////////////
// progress monitor
// done, status and running from completion counts
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module progress_monitor
	import cu_pkg::*;
(
	input  logic        clock,
	input  logic        rstn,
	input  logic        enabled,
	input  wed_t        wed,
	input  logic        request_active,
	input  count_t      vertex_done_count,
	input  count_t      vertex_filtered_count,
	input  count_t      edge_done_count,
	output logic [63:0] algorithm_status,
	output logic        algorithm_done,
	output logic        algorithm_running
);

	count_t vertex_done_q;
	count_t vertex_filtered_q;
	count_t edge_done_q;
	count_t vertex_sum;
	logic done;

	assign vertex_sum = vertex_done_q + vertex_filtered_q;
	assign done = wed.valid && (wed.num_vertices == vertex_sum) &&
		(wed.num_edges == edge_done_q);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_done_q <= '0;
			vertex_filtered_q <= '0;
			edge_done_q <= '0;
			algorithm_status <= '0;
			algorithm_done <= 1'b0;
			algorithm_running <= 1'b0;
		end else if (enabled) begin
			// stage 1: count latch
			vertex_done_q <= vertex_done_count;
			vertex_filtered_q <= vertex_filtered_count;
			edge_done_q <= edge_done_count;
			// stage 2: outputs
			algorithm_status <= wed.valid ? {edge_done_q, vertex_sum} : '0;
			algorithm_done <= done;
			algorithm_running <= request_active;
		end
	end

endmodule

`default_nettype wire

// File: cu_control.sv
////////////////////////////////////////
// compute-unit controller, read side
// latches inputs, merges read commands, routes responses
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "cu_cfg.svh"

module cu_control
	import cu_pkg::*;
(
	input  logic           clock,
	input  logic           rstn,
	input  logic           enable_in,
	input  wed_t           wed_in,
	input  response_line_t read_response_in,
	input  logic [63:0]    algorithm_requests,
	input  cmd_line_t      vertex_cmd,
	input  cmd_line_t      algorithm_cmd,
	input  logic           read_buffer_alfull,
	input  count_t         vertex_done_count,
	input  count_t         vertex_filtered_count,
	input  count_t         edge_done_count,
	output cmd_line_t      read_command_out,
	output buffer_status_t vertex_cmd_status,
	output buffer_status_t algorithm_cmd_status,
	output response_line_t vertex_response,
	output response_line_t algorithm_response,
	output logic [63:0]    algorithm_status,
	output logic           algorithm_done,
	output logic           algorithm_running
);

	logic enabled;
	wed_t wed_latched;
	response_line_t response_latched;
	logic [63:0] requests_latched;

	cmd_line_t [1:0] heads;
	logic [1:0] pops;
	logic hold;
	cmd_line_t arb_cmd;
	cmd_line_t burst_head;
	buffer_status_t burst_status;
	logic burst_pop;

////////////////////////////////////////
// enable and input latching
////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled <= 1'b0;
		end else begin
			enabled <= enable_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wed_latched <= '0;
			response_latched <= '0;
			requests_latched <= '0;
		end else if (enabled) begin
			wed_latched <= wed_in;
			response_latched <= read_response_in;
			// keep the last nonzero request word
			if (|algorithm_requests) begin
				requests_latched <= algorithm_requests;
			end
		end
	end

	response_router i_router (
		.clock             (clock),
		.rstn              (rstn),
		.enabled           (enabled),
		.response_in       (response_latched),
		.vertex_response   (vertex_response),
		.algorithm_response(algorithm_response)
	);

////////////////////////////////////////
// per-source FIFOs and arbitration
////////////////////////////////////////

	cmd_fifo #(
		.DEPTH   (`CU_CMD_FIFO_DEPTH),
		.HEADROOM(`CU_CMD_HEADROOM)
	) i_vertex_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (vertex_cmd.valid),
		.data_in (vertex_cmd),
		.pop     (pops[0]),
		.data_out(heads[0]),
		.status  (vertex_cmd_status)
	);

	cmd_fifo #(
		.DEPTH   (`CU_CMD_FIFO_DEPTH),
		.HEADROOM(`CU_CMD_HEADROOM)
	) i_algorithm_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (algorithm_cmd.valid),
		.data_in (algorithm_cmd),
		.pop     (pops[1]),
		.data_out(heads[1]),
		.status  (algorithm_cmd_status)
	);

	// stop granting while the host or the burst FIFO is backing up
	assign hold = read_buffer_alfull | burst_status.alfull;

	cmd_arbiter i_arbiter (
		.clock  (clock),
		.rstn   (rstn),
		.enabled(enabled),
		.hold   (hold),
		.heads  (heads),
		.pops   (pops),
		.cmd_out(arb_cmd)
	);

////////////////////////////////////////
// burst FIFO and output register
////////////////////////////////////////

	cmd_fifo #(
		.DEPTH   (`CU_BURST_FIFO_DEPTH),
		.HEADROOM(`CU_BURST_HEADROOM)
	) i_burst_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (arb_cmd.valid),
		.data_in (arb_cmd),
		.pop     (burst_pop),
		.data_out(burst_head),
		.status  (burst_status)
	);

	// no pop while disabled, so nothing is dropped at the held register
	assign burst_pop = enabled & ~burst_status.empty & ~read_buffer_alfull;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_command_out <= '0;
		end else if (enabled) begin
			read_command_out <= burst_pop ? burst_head : '0;
		end
	end

	progress_monitor i_progress (
		.clock                (clock),
		.rstn                 (rstn),
		.enabled              (enabled),
		.wed                  (wed_latched),
		.request_active       (|requests_latched),
		.vertex_done_count    (vertex_done_count),
		.vertex_filtered_count(vertex_filtered_count),
		.edge_done_count      (edge_done_count),
		.algorithm_status     (algorithm_status),
		.algorithm_done       (algorithm_done),
		.algorithm_running    (algorithm_running)
	);

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
////////////////////////////////////////
// testbench clock generator
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD = 100
) (
	output logic clock
);

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

endmodule

`default_nettype wire

// File: cu_control_chk.sv
////////////////////////////////////////
// read-side protocol checks on the controller
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module cu_control_chk
	import cu_pkg::*;
(
	input logic           clock,
	input logic           rstn,
	input cmd_line_t      vertex_cmd,
	input cmd_line_t      algorithm_cmd,
	input buffer_status_t vertex_cmd_status,
	input buffer_status_t algorithm_cmd_status,
	input response_line_t vertex_response,
	input response_line_t algorithm_response,
	input logic           read_buffer_alfull,
	input cmd_line_t      read_command_out
);

	// sources never push into a full FIFO
	vertex_push_ok: assert property (@(posedge clock) disable iff (!rstn)
		vertex_cmd.valid |-> !vertex_cmd_status.full)
		else $error("vertex command pushed into a full FIFO");

	algorithm_push_ok: assert property (@(posedge clock) disable iff (!rstn)
		algorithm_cmd.valid |-> !algorithm_cmd_status.full)
		else $error("algorithm command pushed into a full FIFO");

	// one response goes to one port only
	single_route: assert property (@(posedge clock) disable iff (!rstn)
		!(vertex_response.valid && algorithm_response.valid))
		else $error("response routed to both ports");

	// host buffer almost full for two edges, so no command on the third
	alfull_stall: assert property (@(posedge clock) disable iff (!rstn)
		($past(read_buffer_alfull, 2) && $past(read_buffer_alfull)) |->
		!read_command_out.valid)
		else $error("read command issued while the host buffer was almost full");

endmodule

bind cu_control cu_control_chk i_chk (
	.clock               (clock),
	.rstn                (rstn),
	.vertex_cmd          (vertex_cmd),
	.algorithm_cmd       (algorithm_cmd),
	.vertex_cmd_status   (vertex_cmd_status),
	.algorithm_cmd_status(algorithm_cmd_status),
	.vertex_response     (vertex_response),
	.algorithm_response  (algorithm_response),
	.read_buffer_alfull  (read_buffer_alfull),
	.read_command_out    (read_command_out)
);

`default_nettype wire

// File: tb_cu_control.sv
////////////////////////////////////////
// testbench for the compute-unit controller
// random traffic checked against a cycle model
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "cu_cfg.svh"

module tb_cu_control
	import cu_pkg::*;
();

	localparam int PERIOD = 100;
	localparam int NUM_TESTS = 6;
	localparam int TEST_CYCLES = 300;
	localparam int TEST_BUDGET = 2 * TEST_CYCLES;
	localparam cu_id_t VERTEX_SOURCE_ID = '0;

	logic clock;
	logic rstn;
	logic enable_in;
	wed_t wed_in;
	response_line_t read_response_in;
	logic [63:0] algorithm_requests;
	cmd_line_t vertex_cmd;
	cmd_line_t algorithm_cmd;
	logic read_buffer_alfull;
	count_t vertex_done_count;
	count_t vertex_filtered_count;
	count_t edge_done_count;
	cmd_line_t read_command_out;
	buffer_status_t vertex_cmd_status;
	buffer_status_t algorithm_cmd_status;
	response_line_t vertex_response;
	response_line_t algorithm_response;
	logic [63:0] algorithm_status;
	logic algorithm_done;
	logic algorithm_running;

	// last four cycles of driven inputs, indexed by cycle modulo 4
	logic en_h [4] = '{default: 1'b0};
	logic alf_h [4] = '{default: 1'b0};
	logic seen_h [4] = '{default: 1'b0};
	response_line_t resp_h [4] = '{default: '0};
	wed_t wed_h [4] = '{default: '0};
	count_t vd_h [4] = '{default: '0};
	count_t vf_h [4] = '{default: '0};
	count_t ed_h [4] = '{default: '0};

	// commands pushed but not yet seen at the host port
	cmd_line_t vq [$];
	cmd_line_t aq [$];
	cmd_line_t prev_cmd = '0;

	int k = 0;
	int push_pct;
	int alf_pct;
	int en_pct;
	int value_errors = 0;
	int other_errors = 0;
	string test_name = "reset";

	tb_clock_gen #(.PERIOD(PERIOD)) i_clock_gen (.clock(clock));

	cu_control i_dut (.*);

	task automatic report_value(input string what, input logic [79:0] expected,
		input logic [79:0] actual);
		value_errors++;
		$display("error %s %s: expected %h actual %h", test_name, what, expected, actual);
	endtask

	task automatic report_other(input string what);
		other_errors++;
		$display("%s: %s", test_name, what);
	endtask

	task automatic check_reset_outputs();
		buffer_status_t idle;
		idle = '{valid: 1'b0, empty: 1'b1, full: 1'b0, alfull: 1'b0};
		if ({read_command_out, vertex_response, algorithm_response} !== '0) begin
			report_value("command and response ports", 80'(0),
				80'({read_command_out, vertex_response, algorithm_response}));
		end
		if ({algorithm_status, algorithm_done, algorithm_running} !== '0) begin
			report_value("progress outputs", 80'(0),
				80'({algorithm_status, algorithm_done, algorithm_running}));
		end
		if ({vertex_cmd_status, algorithm_cmd_status} !== {idle, idle}) begin
			report_value("FIFO status", 80'({idle, idle}),
				80'({vertex_cmd_status, algorithm_cmd_status}));
		end
	endtask

////////////////////////////////////////
// one clock cycle: check, then drive
////////////////////////////////////////

	task automatic run_cycle();
		int c;
		int p1;
		int p2;
		int p3;
		response_line_t r;
		response_line_t exp_v;
		response_line_t exp_a;
		cmd_line_t exp_cmd;
		count_t vsum;
		logic [63:0] exp_status;
		logic exp_done;
		@(negedge clock);
		c = k % 4;
		p1 = (k + 3) % 4;
		p2 = (k + 2) % 4;
		p3 = (k + 1) % 4;
		// output register updates only on enabled edges
		if (en_h[p2]) begin
			if (alf_h[p1] && read_command_out.valid) begin
				report_other("command delivered while the read buffer was almost full");
			end
			exp_cmd = '0;
			if (read_command_out.valid) begin
				if (read_command_out.cu_id == VERTEX_SOURCE_ID && vq.size() > 0) begin
					exp_cmd = vq.pop_front();
				end else if (read_command_out.cu_id != VERTEX_SOURCE_ID && aq.size() > 0) begin
					exp_cmd = aq.pop_front();
				end
			end
			if (read_command_out !== exp_cmd) begin
				report_value("read command", 80'(exp_cmd), 80'(read_command_out));
			end
		end else if (read_command_out !== prev_cmd) begin
			report_other("read command changed while the controller was disabled");
		end
		prev_cmd = read_command_out;

		// response routed two edges after it was presented
		r = resp_h[p2];
		exp_v = '0;
		exp_a = '0;
		if (en_h[p2] && en_h[p3] && r.valid) begin
			if (r.cu_id == cu_id_t'(`CU_VERTEX_CONTROL_ID)) begin
				exp_v = r;
			end else begin
				exp_a = r;
			end
		end
		if (!en_h[p2] || en_h[p3]) begin
			if (vertex_response !== exp_v) begin
				report_value("vertex response", 80'(exp_v), 80'(vertex_response));
			end
			if (algorithm_response !== exp_a) begin
				report_value("algorithm response", 80'(exp_a), 80'(algorithm_response));
			end
		end

		// progress words from the descriptor and counts of two cycles ago
		if (en_h[p2] && en_h[p3]) begin
			vsum = vd_h[p2] + vf_h[p2];
			exp_status = wed_h[p2].valid ? {ed_h[p2], vsum} : 64'd0;
			exp_done = wed_h[p2].valid && wed_h[p2].num_vertices == vsum &&
				wed_h[p2].num_edges == ed_h[p2];
			if (algorithm_status !== exp_status) begin
				report_value("status", 80'(exp_status), 80'(algorithm_status));
			end
			if (algorithm_done !== exp_done) begin
				report_value("done", 80'(exp_done), 80'(algorithm_done));
			end
		end
		if (en_h[p2] && algorithm_running !== seen_h[p2]) begin
			report_value("running", 80'(seen_h[p2]), 80'(algorithm_running));
		end

		en_h[c] = ($urandom_range(99) < en_pct);
		alf_h[c] = ($urandom_range(99) < alf_pct);
		enable_in = en_h[c];
		read_buffer_alfull = alf_h[c];
		vertex_cmd = '0;
		algorithm_cmd = '0;
		if (!vertex_cmd_status.alfull && $urandom_range(99) < push_pct) begin
			vertex_cmd = '{valid: 1'b1, cu_id: VERTEX_SOURCE_ID,
				address: address_t'($urandom), tag: tag_t'($urandom)};
			vq.push_back(vertex_cmd);
		end
		if (!algorithm_cmd_status.alfull && $urandom_range(99) < push_pct) begin
			algorithm_cmd = '{valid: 1'b1, cu_id: cu_id_t'(1 + $urandom_range(2)),
				address: address_t'($urandom), tag: tag_t'($urandom)};
			aq.push_back(algorithm_cmd);
		end
		resp_h[c] = '{valid: 1'($urandom_range(1)), cu_id: cu_id_t'($urandom),
			tag: tag_t'($urandom)};
		read_response_in = resp_h[c];
		// small counts so that done is hit now and then
		wed_h[c] = '{valid: 1'($urandom_range(1)), num_vertices: count_t'($urandom_range(2)),
			num_edges: count_t'($urandom_range(1))};
		wed_in = wed_h[c];
		vd_h[c] = count_t'($urandom_range(1));
		vf_h[c] = count_t'($urandom_range(1));
		ed_h[c] = count_t'($urandom_range(1));
		vertex_done_count = vd_h[c];
		vertex_filtered_count = vf_h[c];
		edge_done_count = ed_h[c];
		algorithm_requests = ($urandom_range(7) == 0) ? {$urandom, $urandom} : 64'd0;
		seen_h[c] = seen_h[p1] | (en_h[p1] && algorithm_requests != 64'd0);
		k++;
	endtask

	task automatic run_test(input string name, input int push, input int alf, input int en);
		test_name = name;
		push_pct = push;
		alf_pct = alf;
		en_pct = en;
		repeat (TEST_CYCLES) begin
			run_cycle();
		end
	endtask

////////////////////////////////////////
// test sequence and watchdog
////////////////////////////////////////

	initial begin
		int drain;
		void'($urandom(12));
		rstn = 1'b0;
		enable_in = 1'b0;
		wed_in = '0;
		read_response_in = '0;
		algorithm_requests = '0;
		vertex_cmd = '0;
		algorithm_cmd = '0;
		read_buffer_alfull = 1'b0;
		vertex_done_count = '0;
		vertex_filtered_count = '0;
		edge_done_count = '0;
		repeat (10) @(negedge clock);
		rstn = 1'b1;
		@(negedge clock);
		check_reset_outputs();

		run_test("commands", 60, 0, 100);
		run_test("backpressure", 60, 40, 100);
		run_test("responses", 0, 0, 100);
		run_test("progress", 20, 0, 100);
		run_test("enable", 50, 0, 60);

		// enable held high until every pushed command came out
		en_pct = 100;
		push_pct = 0;
		drain = 0;
		while ((vq.size() > 0 || aq.size() > 0) && drain < TEST_CYCLES) begin
			run_cycle();
			drain++;
		end
		repeat (8) begin
			run_cycle();
		end
		if (vq.size() > 0 || aq.size() > 0) begin
			report_other("pushed commands never reached the read command port");
		end

		$display("value errors %0d, other errors %0d", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	initial begin
		#(NUM_TESTS * TEST_BUDGET * PERIOD);
		$display("watchdog: run did not finish within %0d clock periods",
			NUM_TESTS * TEST_BUDGET);
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+.
cu_pkg.sv
cmd_fifo.sv
cmd_arbiter.sv
response_router.sv
progress_monitor.sv
cu_control.sv
tb_clock_gen.sv
cu_control_chk.sv
tb_cu_control.sv

// File: Makefile
TOP = tb_cu_control

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --assert -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir
